// File: design/rv_pkg.sv
package rv_pkg;

    localparam int ILEN = 32;  // base encoding width does not follow XLEN

    // major opcodes this core executes
    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_e;

    // funct3 of OP and OP-IMM
    typedef enum logic [2:0] {
        F3_ADD  = 3'b000,  // add/sub, addi
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SR   = 3'b101,  // srl/sra split by bit 30
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } funct3_e;

    // funct3 of BRANCH where 010 and 011 are unused
    typedef enum logic [2:0] {
        F3_BEQ  = 3'b000,
        F3_BNE  = 3'b001,
        F3_BLT  = 3'b100,
        F3_BGE  = 3'b101,
        F3_BLTU = 3'b110,
        F3_BGEU = 3'b111
    } funct3_br_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU,
        BR_JUMP  // jal and jalr are always taken
    } br_op_e;

endpackage

// File: design/if_id.sv
`timescale 1ns/1ps

module if_id import rv_pkg::*; #(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            inst_valid_i,
    input  logic [ILEN-1:0] inst_i,
    input  logic [XLEN-1:0] inst_addr_i,
    input  logic            flush_i,      // redirect from execute
    output logic            valid_o,
    output logic [ILEN-1:0] inst_o,
    output logic [XLEN-1:0] inst_addr_o
);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= inst_valid_i && !flush_i;  // no strobe gives a bubble
        end
    end

    // payload only moves on a strobe
    always_ff @(posedge clk) begin
        if (inst_valid_i) begin
            inst_o      <= inst_i;
            inst_addr_o <= inst_addr_i;
        end
    end

endmodule

// File: design/id.sv
`timescale 1ns/1ps

module id import rv_pkg::*; #(
    parameter int XLEN = 64
) (
    // from if_id
    input  logic            valid_i,
    input  logic [ILEN-1:0] inst_i,
    input  logic [XLEN-1:0] inst_addr_i,
    // from regs
    input  logic [XLEN-1:0] rs1_data_i,
    input  logic [XLEN-1:0] rs2_data_i,
    // to regs
    output logic [4:0]      rs1_addr_o,
    output logic [4:0]      rs2_addr_o,
    // to id_ex
    output logic [XLEN-1:0] op1_o,
    output logic [XLEN-1:0] op2_o,
    output logic [XLEN-1:0] base_addr_o,
    output logic [XLEN-1:0] offset_addr_o,
    output alu_op_e         alu_op_o,
    output br_op_e          br_op_o,
    output logic [4:0]      rd_addr_o,
    output logic            reg_wen_o
);

    localparam int SHW = $clog2(XLEN);  // 6 on rv64, 5 on rv32

    opcode_e         opcode;
    funct3_e         funct3;
    funct3_br_e      funct3_br;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] shamt_imm;
    logic [XLEN-1:0] shamt_reg;
    logic            wen;
    br_op_e          br;

    assign opcode    = opcode_e'(inst_i[6:0]);
    assign rd        = inst_i[11:7];
    assign funct3    = funct3_e'(inst_i[14:12]);
    assign funct3_br = funct3_br_e'(inst_i[14:12]);
    assign rs1       = inst_i[19:15];
    assign rs2       = inst_i[24:20];
    assign funct7    = inst_i[31:25];

    // every immediate sign extends from inst[31]
    assign imm_i = XLEN'($signed(inst_i[31:20]));
    assign imm_u = XLEN'($signed({inst_i[31:12], 12'b0}));
    assign imm_b = XLEN'($signed({inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0}));
    assign imm_j = XLEN'($signed({inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0}));

    assign shamt_imm = XLEN'(inst_i[20 +: SHW]);
    assign shamt_reg = XLEN'(rs2_data_i[SHW-1:0]);  // rs2 mod XLEN

    always_comb begin
        rs1_addr_o    = 5'd0;
        rs2_addr_o    = 5'd0;
        op1_o         = '0;
        op2_o         = '0;
        base_addr_o   = '0;
        offset_addr_o = '0;
        alu_op_o      = ALU_ADD;
        wen           = 1'b0;
        br            = BR_NONE;
        case (opcode)
            OP_IMM: begin
                rs1_addr_o = rs1;
                op1_o      = rs1_data_i;
                op2_o      = imm_i;
                wen        = 1'b1;
                case (funct3)
                    F3_ADD:  alu_op_o = ALU_ADD;
                    F3_SLT:  alu_op_o = ALU_SLT;
                    F3_SLTU: alu_op_o = ALU_SLTU;
                    F3_XOR:  alu_op_o = ALU_XOR;
                    F3_OR:   alu_op_o = ALU_OR;
                    F3_AND:  alu_op_o = ALU_AND;
                    F3_SLL: begin
                        op2_o    = shamt_imm;
                        alu_op_o = ALU_SLL;
                        wen      = inst_i[31:20+SHW] == '0;  // upper bits must be zero
                    end
                    F3_SR: begin
                        op2_o    = shamt_imm;
                        alu_op_o = inst_i[30] ? ALU_SRA : ALU_SRL;
                        wen      = {inst_i[31], inst_i[29:20+SHW]} == '0;
                    end
                endcase
            end
            OP: begin
                rs1_addr_o = rs1;
                rs2_addr_o = rs2;
                op1_o      = rs1_data_i;
                op2_o      = rs2_data_i;
                // funct7 is zero, or 0100000 for sub and sra only
                wen        = funct7 == 7'b0 ||
                             (funct7 == 7'b0100000 && (funct3 == F3_ADD || funct3 == F3_SR));
                case (funct3)
                    F3_ADD:  alu_op_o = funct7[5] ? ALU_SUB : ALU_ADD;
                    F3_SLT:  alu_op_o = ALU_SLT;
                    F3_SLTU: alu_op_o = ALU_SLTU;
                    F3_XOR:  alu_op_o = ALU_XOR;
                    F3_OR:   alu_op_o = ALU_OR;
                    F3_AND:  alu_op_o = ALU_AND;
                    F3_SLL: begin
                        op2_o    = shamt_reg;
                        alu_op_o = ALU_SLL;
                    end
                    F3_SR: begin
                        op2_o    = shamt_reg;
                        alu_op_o = funct7[5] ? ALU_SRA : ALU_SRL;
                    end
                endcase
            end
            BRANCH: begin
                rs1_addr_o    = rs1;
                rs2_addr_o    = rs2;
                op1_o         = rs1_data_i;  // compared in ex
                op2_o         = rs2_data_i;
                base_addr_o   = inst_addr_i;
                offset_addr_o = imm_b;
                case (funct3_br)
                    F3_BEQ:  br = BR_BEQ;
                    F3_BNE:  br = BR_BNE;
                    F3_BLT:  br = BR_BLT;
                    F3_BGE:  br = BR_BGE;
                    F3_BLTU: br = BR_BLTU;
                    F3_BGEU: br = BR_BGEU;
                    default: br = BR_NONE;
                endcase
            end
            // link address pc + 4 goes through the alu
            JAL: begin
                op1_o         = inst_addr_i;
                op2_o         = XLEN'(4);
                base_addr_o   = inst_addr_i;
                offset_addr_o = imm_j;
                wen           = 1'b1;
                br            = BR_JUMP;
            end
            JALR: begin
                rs1_addr_o    = rs1;
                op1_o         = inst_addr_i;
                op2_o         = XLEN'(4);
                base_addr_o   = rs1_data_i;
                offset_addr_o = imm_i;
                wen           = 1'b1;
                br            = BR_JUMP;
            end
            LUI: begin
                op2_o = imm_u;  // 0 + imm
                wen   = 1'b1;
            end
            AUIPC: begin
                op1_o = inst_addr_i;
                op2_o = imm_u;
                wen   = 1'b1;
            end
            default: ;
        endcase
    end

    // bubbles never write or branch, x0 is never written
    assign rd_addr_o = rd;
    assign reg_wen_o = valid_i && wen && rd != 5'd0;
    assign br_op_o   = valid_i ? br : BR_NONE;

endmodule

// File: design/regs.sv
`timescale 1ns/1ps

module regs #(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic [4:0]      rs1_addr_i,
    input  logic [4:0]      rs2_addr_i,
    // result of the instruction now in execute
    input  logic            ex_wen_i,
    input  logic [4:0]      ex_rd_i,
    input  logic [XLEN-1:0] ex_data_i,
    // registered writeback that lands in the array at the next edge
    input  logic            wb_wen_i,
    input  logic [4:0]      wb_rd_i,
    input  logic [XLEN-1:0] wb_data_i,
    output logic [XLEN-1:0] rs1_data_o,
    output logic [XLEN-1:0] rs2_data_o
);

    logic [XLEN-1:0] rf [1:31];  // x0 not stored

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                rf[i] <= '0;
            end
        end else if (wb_wen_i && wb_rd_i != 5'd0) begin
            rf[wb_rd_i] <= wb_data_i;
        end
    end

    // execute beats writeback, writeback beats the array
    function automatic logic [XLEN-1:0] read_port(input logic [4:0] addr);
        logic [XLEN-1:0] val;
        if (addr == 5'd0) begin
            val = '0;
        end else if (ex_wen_i && ex_rd_i == addr) begin
            val = ex_data_i;
        end else if (wb_wen_i && wb_rd_i == addr) begin
            val = wb_data_i;
        end else begin
            val = rf[addr];
        end
        return val;
    endfunction

    always_comb begin
        rs1_data_o = read_port(rs1_addr_i);
        rs2_data_o = read_port(rs2_addr_i);
    end

endmodule

// File: design/id_ex.sv
`timescale 1ns/1ps

module id_ex import rv_pkg::*; #(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            flush_i,
    input  logic [XLEN-1:0] op1_i,
    input  logic [XLEN-1:0] op2_i,
    input  logic [XLEN-1:0] base_addr_i,
    input  logic [XLEN-1:0] offset_addr_i,
    input  alu_op_e         alu_op_i,
    input  br_op_e          br_op_i,
    input  logic [4:0]      rd_addr_i,
    input  logic            reg_wen_i,
    output logic [XLEN-1:0] op1_o,
    output logic [XLEN-1:0] op2_o,
    output logic [XLEN-1:0] base_addr_o,
    output logic [XLEN-1:0] offset_addr_o,
    output alu_op_e         alu_op_o,
    output br_op_e          br_op_o,
    output logic [4:0]      rd_addr_o,
    output logic            reg_wen_o
);

    // a flush turns the slot into a bubble
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            reg_wen_o <= 1'b0;
            br_op_o   <= BR_NONE;
        end else if (flush_i) begin
            reg_wen_o <= 1'b0;
            br_op_o   <= BR_NONE;
        end else begin
            reg_wen_o <= reg_wen_i;
            br_op_o   <= br_op_i;
        end
    end

    always_ff @(posedge clk) begin
        op1_o         <= op1_i;
        op2_o         <= op2_i;
        base_addr_o   <= base_addr_i;
        offset_addr_o <= offset_addr_i;
        alu_op_o      <= alu_op_i;
        rd_addr_o     <= rd_addr_i;
    end

endmodule

// File: design/ex.sv
`timescale 1ns/1ps

module ex import rv_pkg::*; #(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic [XLEN-1:0] op1_i,
    input  logic [XLEN-1:0] op2_i,
    input  logic [XLEN-1:0] base_addr_i,
    input  logic [XLEN-1:0] offset_addr_i,
    input  alu_op_e         alu_op_i,
    input  br_op_e          br_op_i,
    input  logic [4:0]      rd_addr_i,
    input  logic            reg_wen_i,
    // same-cycle forward to regs
    output logic            fwd_wen_o,
    output logic [4:0]      fwd_rd_o,
    output logic [XLEN-1:0] fwd_data_o,
    // registered writeback and redirect
    output logic            wb_valid_o,
    output logic [4:0]      wb_rd_o,
    output logic [XLEN-1:0] wb_data_o,
    output logic            jump_o,
    output logic [XLEN-1:0] jump_addr_o
);

    localparam int SHW = $clog2(XLEN);

    logic [SHW-1:0]  shamt;
    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] sum_addr;
    logic [XLEN-1:0] target;
    logic            taken;

    assign shamt = op2_i[SHW-1:0];

    always_comb begin
        case (alu_op_i)
            ALU_ADD:  alu_res = op1_i + op2_i;
            ALU_SUB:  alu_res = op1_i - op2_i;
            ALU_SLT:  alu_res = XLEN'($signed(op1_i) < $signed(op2_i));
            ALU_SLTU: alu_res = XLEN'(op1_i < op2_i);
            ALU_XOR:  alu_res = op1_i ^ op2_i;
            ALU_OR:   alu_res = op1_i | op2_i;
            ALU_AND:  alu_res = op1_i & op2_i;
            ALU_SLL:  alu_res = op1_i << shamt;
            ALU_SRL:  alu_res = op1_i >> shamt;
            ALU_SRA:  alu_res = $signed(op1_i) >>> shamt;
            default:  alu_res = '0;
        endcase
    end

    always_comb begin
        case (br_op_i)
            BR_BEQ:  taken = op1_i == op2_i;
            BR_BNE:  taken = op1_i != op2_i;
            BR_BLT:  taken = $signed(op1_i) < $signed(op2_i);
            BR_BGE:  taken = $signed(op1_i) >= $signed(op2_i);
            BR_BLTU: taken = op1_i < op2_i;
            BR_BGEU: taken = op1_i >= op2_i;
            BR_JUMP: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign sum_addr = base_addr_i + offset_addr_i;
    assign target   = {sum_addr[XLEN-1:1], sum_addr[0] && br_op_i != BR_JUMP};  // jalr lsb

    // while a redirect is out, the slot here is wrong-path and dies
    assign fwd_wen_o  = reg_wen_i && !jump_o;
    assign fwd_rd_o   = rd_addr_i;
    assign fwd_data_o = alu_res;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_valid_o <= 1'b0;
            jump_o     <= 1'b0;
        end else begin
            wb_valid_o <= fwd_wen_o;
            jump_o     <= taken && !jump_o;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd_o     <= rd_addr_i;
        wb_data_o   <= alu_res;
        jump_addr_o <= target;
    end

endmodule

// File: design/rv_core.sv
`timescale 1ns/1ps

module rv_core import rv_pkg::*; #(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            inst_valid_i,
    input  logic [ILEN-1:0] inst_i,
    input  logic [XLEN-1:0] inst_addr_i,
    output logic            wb_valid_o,
    output logic [4:0]      wb_rd_o,
    output logic [XLEN-1:0] wb_data_o,
    output logic            jump_o,
    output logic [XLEN-1:0] jump_addr_o
);

    logic            id_valid;
    logic [ILEN-1:0] id_inst;
    logic [XLEN-1:0] id_pc;

    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;

    // decode side of id_ex
    logic [XLEN-1:0] dec_op1;
    logic [XLEN-1:0] dec_op2;
    logic [XLEN-1:0] dec_base;
    logic [XLEN-1:0] dec_offset;
    alu_op_e         dec_alu_op;
    br_op_e          dec_br_op;
    logic [4:0]      dec_rd;
    logic            dec_wen;

    // execute side
    logic [XLEN-1:0] ex_op1;
    logic [XLEN-1:0] ex_op2;
    logic [XLEN-1:0] ex_base;
    logic [XLEN-1:0] ex_offset;
    alu_op_e         ex_alu_op;
    br_op_e          ex_br_op;
    logic [4:0]      ex_rd;
    logic            ex_wen;

    logic            ex_fwd_wen;
    logic [4:0]      ex_fwd_rd;
    logic [XLEN-1:0] ex_fwd_data;

    if_id #(.XLEN(XLEN)) if_id_i (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .inst_addr_i  (inst_addr_i),
        .flush_i      (jump_o),
        .valid_o      (id_valid),
        .inst_o       (id_inst),
        .inst_addr_o  (id_pc)
    );

    id #(.XLEN(XLEN)) id_i (
        .valid_i       (id_valid),
        .inst_i        (id_inst),
        .inst_addr_i   (id_pc),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .op1_o         (dec_op1),
        .op2_o         (dec_op2),
        .base_addr_o   (dec_base),
        .offset_addr_o (dec_offset),
        .alu_op_o      (dec_alu_op),
        .br_op_o       (dec_br_op),
        .rd_addr_o     (dec_rd),
        .reg_wen_o     (dec_wen)
    );

    regs #(.XLEN(XLEN)) regs_i (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .ex_wen_i   (ex_fwd_wen),
        .ex_rd_i    (ex_fwd_rd),
        .ex_data_i  (ex_fwd_data),
        .wb_wen_i   (wb_valid_o),
        .wb_rd_i    (wb_rd_o),
        .wb_data_i  (wb_data_o),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    id_ex #(.XLEN(XLEN)) id_ex_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .flush_i       (jump_o),
        .op1_i         (dec_op1),
        .op2_i         (dec_op2),
        .base_addr_i   (dec_base),
        .offset_addr_i (dec_offset),
        .alu_op_i      (dec_alu_op),
        .br_op_i       (dec_br_op),
        .rd_addr_i     (dec_rd),
        .reg_wen_i     (dec_wen),
        .op1_o         (ex_op1),
        .op2_o         (ex_op2),
        .base_addr_o   (ex_base),
        .offset_addr_o (ex_offset),
        .alu_op_o      (ex_alu_op),
        .br_op_o       (ex_br_op),
        .rd_addr_o     (ex_rd),
        .reg_wen_o     (ex_wen)
    );

    ex #(.XLEN(XLEN)) ex_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .op1_i         (ex_op1),
        .op2_i         (ex_op2),
        .base_addr_i   (ex_base),
        .offset_addr_i (ex_offset),
        .alu_op_i      (ex_alu_op),
        .br_op_i       (ex_br_op),
        .rd_addr_i     (ex_rd),
        .reg_wen_i     (ex_wen),
        .fwd_wen_o     (ex_fwd_wen),
        .fwd_rd_o      (ex_fwd_rd),
        .fwd_data_o    (ex_fwd_data),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o),
        .jump_o        (jump_o),
        .jump_addr_o   (jump_addr_o)
    );

endmodule

// File: tb/rv_tests.svh
// base ISA encoders
function automatic logic [31:0] itype(input logic [6:0] op, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [4:0] rs1,
                                      input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] rtype(input logic [2:0] f3, input logic alt,
                                      input logic [4:0] rd, input logic [4:0] rs1,
                                      input logic [4:0] rs2);
    return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OP};  // alt is bit 30
endfunction

function automatic logic [31:0] utype(input logic [6:0] op, input logic [4:0] rd,
                                      input logic [19:0] imm);
    return {imm, rd, op};
endfunction

function automatic logic [31:0] btype(input logic [2:0] f3, input logic [4:0] rs1,
                                      input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], BRANCH};
endfunction

function automatic logic [31:0] jtype(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, JAL};
endfunction

// RV64I result of an OP or OP-IMM funct3 with the shift amount taken mod 64
function automatic logic [63:0] alu_result(input logic [2:0] f3, input logic alt,
                                           input logic [63:0] a, input logic [63:0] b);
    case (f3)
        3'd0: begin
            if (alt) return a - b;
            return a + b;
        end
        3'd1:    return a << b[5:0];
        3'd2:    return $signed(a) < $signed(b);
        3'd3:    return a < b;
        3'd4:    return a ^ b;
        3'd5: begin
            if (alt) return $signed(a) >>> b[5:0];
            return a >> b[5:0];
        end
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic branch_taken(input logic [2:0] f3, input logic [63:0] a,
                                      input logic [63:0] b);
    case (f3)
        F3_BEQ:  return a == b;
        F3_BNE:  return a != b;
        F3_BLT:  return $signed(a) < $signed(b);
        F3_BGE:  return $signed(a) >= $signed(b);
        F3_BLTU: return a < b;
        default: return a >= b;
    endcase
endfunction

// lui then a dependent addi
function automatic void load_const(input logic [4:0] rd, input logic [31:0] v);
    logic [19:0] hi;
    hi = 20'((v + 32'h800) >> 12);
    put(utype(LUI, rd, hi));
    want(rd, {{32{hi[19]}}, hi, 12'b0});
    put(itype(OP_IMM, F3_ADD, rd, rd, v[11:0]));
    want(rd, shadow[rd] + {{52{v[11]}}, v[11:0]});
endfunction

function automatic void load_small(input logic [4:0] rd, input logic [11:0] imm);
    put(itype(OP_IMM, F3_ADD, rd, 5'd0, imm));
    want(rd, {{52{imm[11]}}, imm});
endfunction

task automatic idle_after_reset();
    logic [11:0] imm;
    imm = 12'($urandom());
    repeat (8) begin
        @(negedge clk);
        check("wb_valid_o", wb_valid_o, 1'b0);
        check("jump_o", jump_o, 1'b0);
    end
    begin_program();
    load_small(5'd3, imm);
    put(rtype(F3_ADD, 1'b0, 5'd4, 5'd5, 5'd6));  // sources never written read 0
    want(5'd4, 64'd0);
    run_program();
    compare_results("reset");
endtask

task automatic imm_alu_ops();
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm;
    begin_program();
    for (int k = 0; k < 9; k++) begin
        f3  = (k == 8) ? 3'd5 : 3'(k);  // srai last
        alt = (k == 8);
        load_const(5'd1, $urandom());
        // first use forwards from execute, second from writeback
        for (int n = 0; n < 2; n++) begin
            imm = 12'($urandom());
            if (f3 == 3'd1 || f3 == 3'd5) begin
                imm = {1'b0, alt, 4'b0, imm[5:0]};
            end
            put(itype(OP_IMM, f3, 5'(10 + 2 * k + n), 5'd1, imm));
            want(5'(10 + 2 * k + n), alu_result(f3, alt, shadow[1], {{52{imm[11]}}, imm}));
        end
    end
    run_program();
    compare_results("imm ops");
endtask

task automatic reg_alu_ops();
    logic [2:0] f3;
    logic       alt;
    begin_program();
    load_const(5'd1, $urandom());
    load_const(5'd2, $urandom());
    for (int k = 0; k < 10; k++) begin
        f3  = (k < 8) ? 3'(k) : ((k == 8) ? 3'd0 : 3'd5);  // then sub and sra
        alt = (k >= 8);
        put(rtype(f3, alt, 5'(10 + k), 5'd1, 5'd2));
        want(5'(10 + k), alu_result(f3, alt, shadow[1], shadow[2]));
    end
    put(rtype(F3_ADD, 1'b0, 5'd0, 5'd1, 5'd2));  // no writeback
    put(rtype(F3_OR, 1'b0, 5'd3, 5'd0, 5'd1));
    want(5'd3, shadow[1]);
    run_program();
    compare_results("reg ops");
endtask

task automatic upper_imm_ops();
    logic [19:0] u;
    logic [63:0] pc;
    begin_program();
    u = 20'($urandom());
    put(utype(LUI, 5'd7, u));
    want(5'd7, {{32{u[19]}}, u, 12'b0});
    u  = 20'($urandom());
    pc = 64'(plen * 4);
    put(utype(AUIPC, 5'd8, u));
    want(5'd8, pc + {{32{u[19]}}, u, 12'b0});
    run_program();
    compare_results("lui auipc");
endtask

task automatic branch_cases();
    logic [2:0]  f3;
    logic [11:0] a_imm;
    logic [11:0] b_imm;
    logic        taken;
    logic [63:0] pc;
    begin_program();
    for (int p = 0; p < 3; p++) begin
        // -1/1, 5/5 and 1/-1 split signed from unsigned compares
        a_imm = (p == 0) ? 12'hfff : ((p == 1) ? 12'd5 : 12'd1);
        b_imm = (p == 0) ? 12'd1 : ((p == 1) ? 12'd5 : 12'hfff);
        load_small(5'd1, a_imm);
        load_small(5'd2, b_imm);
        for (int k = 0; k < 6; k++) begin
            f3    = (k < 2) ? 3'(k) : 3'(k + 2);
            taken = branch_taken(f3, shadow[1], shadow[2]);
            pc    = 64'(plen * 4);
            put(btype(f3, 5'd1, 5'd2, 13'd16));  // skips three
            for (int n = 0; n < 4; n++) begin
                put(itype(OP_IMM, F3_ADD, 5'(20 + n), 5'd0, 12'(n + 1)));
                if (!taken || n == 3) begin
                    want(5'(20 + n), 64'(n + 1));
                end
            end
            if (taken) begin
                expect_jump(pc + 64'd16);
            end
        end
    end
    run_program();
    compare_results("branches");
endtask

task automatic jump_and_link();
    begin_program();
    put(jtype(5'd5, 21'd12));  // pc 0
    want(5'd5, 64'd4);
    expect_jump(64'd12);
    put(jtype(5'd20, 21'd40));  // wrong-path jal never redirects
    put(itype(OP_IMM, F3_ADD, 5'd21, 5'd0, 12'd2));
    load_small(5'd6, 12'd29);  // pc 12 with an odd base
    put(itype(JALR, 3'd0, 5'd7, 5'd6, 12'd4));  // pc 16
    want(5'd7, 64'd20);
    expect_jump((shadow[6] + 64'd4) & ~64'd1);
    for (int n = 0; n < 3; n++) begin
        put(itype(OP_IMM, F3_ADD, 5'(22 + n), 5'd0, 12'd9));
    end
    load_small(5'd25, 12'd7);  // pc 32
    run_program();
    compare_results("jal jalr");
endtask

task automatic link_latency();
    int lat;
    begin_program();
    want(5'd9, 64'h104);
    expect_jump(64'hf8);
    @(posedge clk);
    inst_valid_i <= 1'b1;
    inst_i       <= jtype(5'd9, 21'h1ffff8);  // jal x9, -8
    inst_addr_i  <= 64'h100;
    lat = 0;
    do begin
        @(posedge clk);
        inst_valid_i <= 1'b0;
        lat++;
        @(negedge clk);
    end while (!wb_valid_o && lat < 10);
    check("wb_valid_o cycles after strobe", lat, 3);
    check("jump_o", jump_o, 1'b1);
    repeat (4) @(posedge clk);
    compare_results("link latency");
endtask

// File: tb/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core import rv_pkg::*; ();

    localparam int XLEN         = 64;
    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int PROG_WORDS   = 162;  // all programs in rv_tests.svh together
    localparam int TIMEOUT_NS   = (RESET_CYCLES + PROG_WORDS * 4 + 200) * CLK_PERIOD;

    logic            clk = 1'b0;
    logic            rst_n_i;
    logic            inst_valid_i;
    logic [ILEN-1:0] inst_i;
    logic [XLEN-1:0] inst_addr_i;
    logic            wb_valid_o;
    logic [4:0]      wb_rd_o;
    logic [XLEN-1:0] wb_data_o;
    logic            jump_o;
    logic [XLEN-1:0] jump_addr_o;

    logic [ILEN-1:0] prog [0:255];  // indexed by pc / 4
    int              plen;
    logic [XLEN-1:0] shadow [0:31];  // expected architectural registers
    logic [4:0]      wb_rd_q[$];
    logic [XLEN-1:0] wb_data_q[$];
    logic [XLEN-1:0] jmp_q[$];
    logic [4:0]      exp_rd_q[$];
    logic [XLEN-1:0] exp_data_q[$];
    logic [XLEN-1:0] exp_jmp_q[$];

    always #(CLK_PERIOD / 2) clk = ~clk;

    rv_core #(.XLEN(XLEN)) rv_core_i (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .inst_addr_i  (inst_addr_i),
        .wb_valid_o   (wb_valid_o),
        .wb_rd_o      (wb_rd_o),
        .wb_data_o    (wb_data_o),
        .jump_o       (jump_o),
        .jump_addr_o  (jump_addr_o)
    );

    // collects every writeback and redirect
    always @(negedge clk) begin
        if (wb_valid_o) begin
            wb_rd_q.push_back(wb_rd_o);
            wb_data_q.push_back(wb_data_o);
        end
        if (jump_o) begin
            jmp_q.push_back(jump_addr_o);
        end
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check(input string name, input logic [XLEN-1:0] got,
                         input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    function automatic void begin_program();
        plen = 0;
        wb_rd_q.delete();
        wb_data_q.delete();
        jmp_q.delete();
        exp_rd_q.delete();
        exp_data_q.delete();
        exp_jmp_q.delete();
    endfunction

    function automatic void put(input logic [ILEN-1:0] inst);
        prog[plen] = inst;
        plen++;
    endfunction

    // x0 destinations retire silently
    function automatic void want(input logic [4:0] rd, input logic [XLEN-1:0] value);
        if (rd != 5'd0) begin
            exp_rd_q.push_back(rd);
            exp_data_q.push_back(value);
            shadow[rd] = value;
        end
    endfunction

    function automatic void expect_jump(input logic [XLEN-1:0] target);
        exp_jmp_q.push_back(target);
    endfunction

    // instruction source that follows redirects
    task automatic run_program();
        logic [XLEN-1:0] pc;
        int              quiet;
        pc    = '0;
        quiet = 0;
        while (quiet < 6) begin
            @(posedge clk);
            if (pc < XLEN'(plen * 4)) begin
                inst_valid_i <= 1'b1;
                inst_i       <= prog[pc[9:2]];
                inst_addr_i  <= pc;
                pc    = pc + 4;
                quiet = 0;
            end else begin
                inst_valid_i <= 1'b0;
                quiet++;  // a late redirect can still come back
            end
            @(negedge clk);
            if (jump_o) begin
                pc = jump_addr_o;
            end
        end
    endtask

    task automatic compare_results(input string test);
        while (exp_rd_q.size() > 0) begin
            if (wb_rd_q.size() == 0) begin
                fail_now($sformatf("%s: writeback to x%0d never came", test, exp_rd_q[0]));
            end else begin
                check($sformatf("%s wb_rd_o", test), wb_rd_q.pop_front(), exp_rd_q.pop_front());
                check($sformatf("%s wb_data_o", test), wb_data_q.pop_front(),
                      exp_data_q.pop_front());
            end
        end
        while (exp_jmp_q.size() > 0) begin
            if (jmp_q.size() == 0) begin
                fail_now($sformatf("%s: expected redirect was not raised", test));
            end else begin
                check($sformatf("%s jump_addr_o", test), jmp_q.pop_front(), exp_jmp_q.pop_front());
            end
        end
        if (wb_rd_q.size() != 0) begin
            fail_now($sformatf("%s: unexpected writeback to x%0d", test, wb_rd_q[0]));
        end
        if (jmp_q.size() != 0) begin
            fail_now($sformatf("%s: unexpected redirect to 0x%h", test, jmp_q[0]));
        end
    endtask

    `include "rv_tests.svh"

    initial begin
        #(TIMEOUT_NS);
        fail_now("watchdog: the run did not finish in time");
    end

    initial begin
        void'($urandom(41));
        rst_n_i      = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        inst_addr_i  = '0;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n_i <= 1'b1;

        idle_after_reset();
        imm_alu_ops();
        reg_alu_ops();
        upper_imm_ops();
        branch_cases();
        jump_and_link();
        link_latency();

        $display("TEST PASS");
        $finish;
    end

endmodule

// File: project.f
+incdir+tb
design/rv_pkg.sv
design/if_id.sv
design/id.sv
design/regs.sv
design/id_ex.sv
design/ex.sv
design/rv_core.sv
tb/tb_rv_core.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - design/rv_pkg.sv
  - design/if_id.sv
  - design/id.sv
  - design/regs.sv
  - design/id_ex.sv
  - design/ex.sv
  - design/rv_core.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_rv_core.sv
